//--- simmem_write_only.f
hdl/simmem_pkg.sv
hdl/simmem_delay_calc.sv
hdl/simmem_delay_bank.sv
hdl/simmem_write_resp_bank.sv
hdl/simmem_write_only.sv
verif/simmem_write_only_props.sv
verif/simmem_write_only_tb.sv

//--- Makefile
# Verilator build and run for the simulated memory controller write path

SHELL     := /bin/bash
VERILATOR ?= verilator
TOP       ?= simmem_write_only_tb
FILELIST  ?= simmem_write_only.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Simulation finished: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/simmem_write_only_tb.sv
/*
 * Write path testbench
 * Reference row model and per-ID scoreboard over six directed and random tests
 */

`timescale 1ns/100ps

module simmem_write_only_tb;

  import simmem_pkg::*;

  localparam int ClkPeriod     = 8;
  localparam int ResetCycles   = 16;
  localparam int NumTests      = 6;
  localparam int CyclesPerTest = 400;
  localparam int MaxCycles     = NumTests * CyclesPerTest + 1600;
  localparam logic [IdWidth-1:0] UnknownId = 4'hF;

  logic clk_i, rst_n_i;
  logic write_addr_in_valid_i, write_addr_in_ready_o;
  logic write_addr_out_valid_o, write_addr_out_ready_i;
  logic write_resp_in_valid_i, write_resp_in_ready_o;
  logic write_resp_out_valid_o, write_resp_out_ready_i;
  write_addr_req_t write_addr_req_i, write_addr_req_o;
  write_resp_t     write_resp_i, write_resp_o;

  // Scoreboard, per ID in reservation order
  int exp_tag [16][$];
  int exp_res [16][$];
  int exp_dly [16][$];
  int acc_cyc [256];
  logic [11:0] pend_q [$];
  int cycle, errors, outstanding, addr_fires, appear_cyc, tests_passed;
  logic [7:0] next_tag;
  logic appear_pending, resp_taken, resp_enable, inject_unknown;
  logic out_ready_rand, mem_ready_rand;
  // Reference row model
  logic ref_open;
  int   ref_row;

  simmem_write_only dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic report_fail(input string msg);
    $display("Fail %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic record_reservation();
    int row;
    int dly;
    logic [3:0] id;
    row = int'(write_addr_req_i.addr[AddrWidth-1:RowOffset]);
    id  = write_addr_req_i.id;
    if (!ref_open) dly = 12;
    else if (row == ref_row) dly = 4;
    else dly = 16;
    ref_open = 1'b1;
    ref_row  = row;
    exp_tag[id].push_back(int'(next_tag));
    exp_res[id].push_back(cycle);
    exp_dly[id].push_back(dly);
    pend_q.push_back({id, next_tag});
    next_tag++;
    outstanding++;
    addr_fires++;
  endtask

  task automatic check_output();
    int tag, res, dly;
    logic [3:0] id;
    id = write_resp_o.id;
    assert (exp_tag[id].size() > 0) else begin
      report_fail($sformatf("response for ID %0d with nothing outstanding", id));
      return;
    end
    tag = exp_tag[id].pop_front();
    res = exp_res[id].pop_front();
    dly = exp_dly[id].pop_front();
    assert (int'(write_resp_o.user) == tag)
      else report_fail($sformatf("ID %0d tag %0d, expected %0d", id, write_resp_o.user, tag));
    assert (write_resp_o.resp == 2'(tag))
      else report_fail($sformatf("tag %0d resp %0d, expected %0d", tag, write_resp_o.resp,
                                 2'(tag)));
    assert (appear_cyc >= res + dly)
      else report_fail($sformatf("tag %0d out at %0d before delay end %0d", tag, appear_cyc,
                                 res + dly));
    assert (appear_cyc >= acc_cyc[tag] + 1)
      else report_fail($sformatf("tag %0d out before its acceptance", tag));
    outstanding--;
  endtask

  // Monitor, samples at the rising edge
  always @(posedge clk_i) begin
    cycle++;
    if (cycle >= MaxCycles) begin
      $display("Timeout: run did not end within %0d cycles", MaxCycles);
      $display("Simulation finished: FAIL");
      $finish;
    end else if (rst_n_i) begin
      if (write_addr_in_valid_i && write_addr_in_ready_o) record_reservation();
      if (write_resp_in_valid_i && write_resp_in_ready_o) begin
        assert (write_resp_i.id != UnknownId)
          else report_fail("response with unknown ID was accepted");
        acc_cyc[write_resp_i.user] = cycle;
        resp_taken = 1'b1;
      end
      if (write_resp_out_valid_o && appear_pending) begin
        appear_cyc     = cycle - 1;
        appear_pending = 1'b0;
      end
      if (write_resp_out_valid_o && write_resp_out_ready_i) begin
        check_output();
        appear_pending = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Drivers on the falling edge
  //////////////////////////////

  always @(negedge clk_i) begin
    write_addr_out_ready_i = mem_ready_rand ? 1'($urandom % 2) : 1'b1;
    write_resp_out_ready_i = out_ready_rand ? 1'($urandom % 2) : 1'b1;
    if (resp_taken) begin
      void'(pend_q.pop_front());
      resp_taken            = 1'b0;
      write_resp_in_valid_i = 1'b0;
    end
    if (inject_unknown) begin
      write_resp_in_valid_i = 1'b1;
      write_resp_i          = '{id: UnknownId, resp: 2'b00, user: 8'hee};
    end else if (resp_enable && pend_q.size() > 0) begin
      if (!write_resp_in_valid_i) write_resp_in_valid_i = ($urandom % 4) != 0;
      // Response code taken from the low tag bits
      write_resp_i = '{id: pend_q[0][11:8], resp: pend_q[0][1:0], user: pend_q[0][7:0]};
    end else begin
      write_resp_in_valid_i = 1'b0;
    end
  end

  task automatic send_addr(input logic [3:0] id, input int row);
    int start;
    start = addr_fires;
    write_addr_req_i = '{id: id, addr: (AddrWidth'(row) << RowOffset) |
                         AddrWidth'($urandom % 1024), len: 8'd0, size: 3'd2, burst: 2'b01};
    write_addr_in_valid_i = 1'b1;
    do @(negedge clk_i); while (addr_fires == start);
    write_addr_in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (outstanding != 0 || write_resp_out_valid_o) @(negedge clk_i);
  endtask

  task automatic finish_test(input int num, input string name, input int err_start);
    $display("Test %0d %s: %s", num, name, (errors == err_start) ? "ok" : "errors");
    if (errors == err_start) tests_passed++;
  endtask

  initial begin
    int e;
    int row;
    int fires;
    void'($urandom(32'h01ca_3b29));
    {rst_n_i, write_addr_in_valid_i, write_resp_in_valid_i} = '0;
    {write_addr_out_ready_i, write_resp_out_ready_i} = 2'b11;
    write_addr_req_i = '0;
    write_resp_i     = '0;
    {cycle, errors, outstanding, addr_fires, appear_cyc, tests_passed} = '0;
    {next_tag, ref_row} = '0;
    {resp_taken, inject_unknown, out_ready_rand, mem_ready_rand, ref_open} = '0;
    {appear_pending, resp_enable} = 2'b11;
    repeat (ResetCycles) @(negedge clk_i);
    rst_n_i = 1'b1;

    // 1: idle outputs after reset
    e = errors;
    @(negedge clk_i);
    assert (!write_resp_out_valid_o) else report_fail("response valid after reset");
    assert (write_addr_in_ready_o == write_addr_out_ready_i)
      else report_fail("address ready differs from memory ready");
    finish_test(1, "reset", e);

    // 2: closed row, same-row hit, different-row conflict
    e = errors;
    row = int'($urandom % 4);
    send_addr(4'($urandom % 15), row);
    send_addr(4'($urandom % 15), row);
    send_addr(4'($urandom % 15), row + 1 + int'($urandom % 5));
    wait_drain();
    finish_test(2, "delay bound", e);

    // 3: one ID, tags must come back in order
    e = errors;
    for (int i = 0; i < 6; i++) send_addr(4'd3, int'($urandom % 3));
    wait_drain();
    finish_test(3, "per-ID order", e);

    // 4: fill every slot with responses held back
    e = errors;
    resp_enable = 1'b0;
    for (int i = 0; i < RespBanksCapacity; i++) send_addr(4'($urandom % 15), int'($urandom % 4));
    fires = addr_fires;
    write_addr_req_i.id   = 4'd5;
    write_addr_in_valid_i = 1'b1;
    repeat (20) begin
      @(negedge clk_i);
      assert (!write_addr_in_ready_o && !write_addr_out_valid_o)
        else report_fail("address accepted with all slots busy");
    end
    resp_enable = 1'b1;
    // Held request takes the first slot that frees up
    while (addr_fires == fires) @(negedge clk_i);
    write_addr_in_valid_i = 1'b0;
    wait_drain();
    finish_test(4, "capacity", e);

    // 5: response with no waiting slot
    e = errors;
    inject_unknown = 1'b1;
    repeat (10) begin
      @(negedge clk_i);
      assert (!write_resp_in_ready_o) else report_fail("ready high for unknown ID");
    end
    inject_unknown = 1'b0;
    repeat (30) @(negedge clk_i);
    assert (!write_resp_out_valid_o) else report_fail("unknown ID reached the output");
    finish_test(5, "unknown ID", e);

    // 6: random ready on both sides
    e = errors;
    out_ready_rand = 1'b1;
    mem_ready_rand = 1'b1;
    for (int i = 0; i < 20; i++) send_addr(4'($urandom % 15), int'($urandom % 4));
    wait_drain();
    out_ready_rand = 1'b0;
    mem_ready_rand = 1'b0;
    finish_test(6, "back-pressure", e);

    $display("Tests passed: %0d of %0d, errors: %0d", tests_passed, NumTests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verif/simmem_write_only_props.sv
/*
 * Write path properties
 * Reset, capacity stall, pass-through and output stability rules
 */

`timescale 1ns/100ps

module simmem_write_only_props (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    write_addr_in_valid_i,
  input logic                    write_addr_in_ready_o,
  input logic                    write_addr_out_valid_o,
  input logic                    write_addr_out_ready_i,
  input simmem_pkg::write_addr_req_t write_addr_req_i,
  input simmem_pkg::write_addr_req_t write_addr_req_o,
  input logic                    write_resp_out_valid_o,
  input logic                    write_resp_out_ready_i,
  input simmem_pkg::write_resp_t write_resp_o
);

  import simmem_pkg::*;

  localparam int unsigned CntWidth = SlotIdxWidth + 1;

  logic                addr_fire;
  logic                out_fire;
  logic [CntWidth-1:0] outst_q;
  logic [CntWidth-1:0] slots_busy;

  assign addr_fire = write_addr_in_valid_i && write_addr_in_ready_o;
  assign out_fire  = write_resp_out_valid_o && write_resp_out_ready_i;

  // Reservations not yet handed back to the requester
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outst_q <= '0;
    end else begin
      outst_q <= outst_q + CntWidth'(addr_fire) - CntWidth'(out_fire);
    end
  end

  // The response in the output register has already left its slot
  assign slots_busy = outst_q - CntWidth'(write_resp_out_valid_o);

  // Output register empty right after reset
  a_reset_out_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> !write_resp_out_valid_o)
    else $error("response valid high after reset");

  // All slots free after reset, so ready follows the memory side
  a_reset_addr_ready: assert property (@(posedge clk_i)
    rst_n_i && !$past(rst_n_i) |-> write_addr_in_ready_o == write_addr_out_ready_i)
    else $error("address ready does not follow memory ready after reset");

  // Full bank stalls both sides of the address channel
  a_full_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slots_busy == CntWidth'(RespBanksCapacity) |->
      !write_addr_in_ready_o && !write_addr_out_valid_o)
    else $error("address channel not stalled with all slots busy");

  // A free slot lets the memory side ready through
  a_free_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slots_busy < CntWidth'(RespBanksCapacity) |->
      write_addr_in_ready_o == write_addr_out_ready_i)
    else $error("address channel stalled with a slot free");

  a_addr_pass: assert property (@(posedge clk_i)
    write_addr_req_o == write_addr_req_i)
    else $error("address payload altered");

  // Held response under back-pressure
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    write_resp_out_valid_o && !write_resp_out_ready_i |=>
      write_resp_out_valid_o && $stable(write_resp_o))
    else $error("response changed before transfer");

endmodule

bind simmem_write_only simmem_write_only_props props0 (
  .clk_i                  (clk_i),
  .rst_n_i                (rst_n_i),
  .write_addr_in_valid_i  (write_addr_in_valid_i),
  .write_addr_in_ready_o  (write_addr_in_ready_o),
  .write_addr_out_valid_o (write_addr_out_valid_o),
  .write_addr_out_ready_i (write_addr_out_ready_i),
  .write_addr_req_i       (write_addr_req_i),
  .write_addr_req_o       (write_addr_req_o),
  .write_resp_out_valid_o (write_resp_out_valid_o),
  .write_resp_out_ready_i (write_resp_out_ready_i),
  .write_resp_o           (write_resp_o)
);

//--- hdl/simmem_write_only.sv
/*
 * Simulated memory controller, write path
 * Passes write addresses through and delays write responses by a DRAM row model
 */

`timescale 1ns/100ps

module simmem_write_only (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // Requester address in
  input  logic                        write_addr_in_valid_i,
  output logic                        write_addr_in_ready_o,
  input  simmem_pkg::write_addr_req_t write_addr_req_i,

  // Memory address out
  output logic                        write_addr_out_valid_o,
  input  logic                        write_addr_out_ready_i,
  output simmem_pkg::write_addr_req_t write_addr_req_o,

  // Memory response in
  input  logic                        write_resp_in_valid_i,
  output logic                        write_resp_in_ready_o,
  input  simmem_pkg::write_resp_t     write_resp_i,

  // Requester response out
  output logic                        write_resp_out_valid_o,
  input  logic                        write_resp_out_ready_i,
  output simmem_pkg::write_resp_t     write_resp_o
);

  import simmem_pkg::*;

  logic                         res_ready;
  logic                         res_fire;
  logic [RespBanksCapacity-1:0] res_slot_onehot;
  logic [RespBanksCapacity-1:0] release_en;
  logic [DelayWidth-1:0]        res_delay;

  //////////////////////////////
  // Address channel
  //////////////////////////////

  // Straight through, stalls only when every slot is taken
  assign write_addr_out_valid_o = write_addr_in_valid_i && res_ready;
  assign write_addr_in_ready_o  = write_addr_out_ready_i && res_ready;
  assign write_addr_req_o       = write_addr_req_i;

  // Both sides transfer together
  assign res_fire = write_addr_in_valid_i && write_addr_out_ready_i && res_ready;

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////

  simmem_delay_calc i_delay_calc (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .addr_i     (write_addr_req_i.addr),
    .res_fire_i (res_fire),
    .delay_o    (res_delay)
  );

  simmem_delay_bank i_delay_bank (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .res_slot_onehot_i (res_slot_onehot),
    .delay_i           (res_delay),
    .release_en_o      (release_en)
  );

  simmem_write_resp_bank i_write_resp_bank (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .res_valid_i       (res_fire),
    .res_id_i          (write_addr_req_i.id),
    .res_ready_o       (res_ready),
    .res_slot_onehot_o (res_slot_onehot),
    .release_en_i      (release_en),
    .resp_in_valid_i   (write_resp_in_valid_i),
    .resp_i            (write_resp_i),
    .resp_in_ready_o   (write_resp_in_ready_o),
    .resp_out_ready_i  (write_resp_out_ready_i),
    .resp_out_valid_o  (write_resp_out_valid_o),
    .resp_o            (write_resp_o)
  );

endmodule

//--- hdl/simmem_write_resp_bank.sv
/*
 * Write response bank
 * Reserves a slot per write address, stores responses by ID in age order
 * and releases the oldest expired response through a registered output
 */

`timescale 1ns/100ps

module simmem_write_resp_bank (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  // Reservation side
  input  logic                                     res_valid_i,
  input  logic [simmem_pkg::IdWidth-1:0]           res_id_i,
  output logic                                     res_ready_o,
  output logic [simmem_pkg::RespBanksCapacity-1:0] res_slot_onehot_o,

  // Expired counters from the delay bank
  input  logic [simmem_pkg::RespBanksCapacity-1:0] release_en_i,

  // Responses from the memory side
  input  logic                                     resp_in_valid_i,
  input  simmem_pkg::write_resp_t                  resp_i,
  output logic                                     resp_in_ready_o,

  // Responses to the requester
  input  logic                                     resp_out_ready_i,
  output logic                                     resp_out_valid_o,
  output simmem_pkg::write_resp_t                  resp_o
);

  import simmem_pkg::*;

  // a is older than b, modulo the stamp range
  function automatic logic is_older(input logic [AgeWidth-1:0] a,
                                    input logic [AgeWidth-1:0] b);
    logic [AgeWidth-1:0] diff;
    diff = a - b;
    return diff[AgeWidth-1];
  endfunction

  // Keeps only the oldest candidate, stamps of live slots are distinct
  function automatic logic [RespBanksCapacity-1:0] pick_oldest(
    input logic [RespBanksCapacity-1:0] cand,
    input logic [AgeWidth-1:0]          ages [RespBanksCapacity]
  );
    logic [RespBanksCapacity-1:0] pick;
    pick = cand;
    for (int i = 0; i < RespBanksCapacity; i++) begin
      for (int j = 0; j < RespBanksCapacity; j++) begin
        if (cand[i] && cand[j] && (i != j) && is_older(ages[j], ages[i])) begin
          pick[i] = 1'b0;
        end
      end
    end
    return pick;
  endfunction

  slot_state_e          state_q [RespBanksCapacity];
  logic [IdWidth-1:0]   id_q    [RespBanksCapacity];
  logic [AgeWidth-1:0]  age_q   [RespBanksCapacity];
  write_resp_t          resp_q  [RespBanksCapacity];
  logic [AgeWidth-1:0]  age_cnt_q;

  logic [RespBanksCapacity-1:0] free_mask;
  logic [RespBanksCapacity-1:0] wait_match;
  logic [RespBanksCapacity-1:0] id_head;
  logic [RespBanksCapacity-1:0] eligible;
  logic [RespBanksCapacity-1:0] alloc_onehot;
  logic [RespBanksCapacity-1:0] fill_onehot;
  logic [RespBanksCapacity-1:0] rel_onehot;
  logic [SlotIdxWidth-1:0]      rel_idx;
  logic                         res_fire;
  logic                         fill_fire;
  logic                         out_load;
  logic                         out_valid_q;
  write_resp_t                  out_data_q;

  //////////////////////////////
  // Slot masks
  //////////////////////////////

  // Oldest live slot of each ID, only these may leave
  always_comb begin
    for (int i = 0; i < RespBanksCapacity; i++) begin
      id_head[i] = 1'b1;
      for (int j = 0; j < RespBanksCapacity; j++) begin
        if ((j != i) && (state_q[j] != SLOT_FREE) && (id_q[j] == id_q[i]) &&
            is_older(age_q[j], age_q[i])) begin
          id_head[i] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < RespBanksCapacity; i++) begin
      free_mask[i]  = (state_q[i] == SLOT_FREE);
      wait_match[i] = (state_q[i] == SLOT_WAIT_RESP) && (id_q[i] == resp_i.id);
      eligible[i]   = (state_q[i] == SLOT_FILLED) && release_en_i[i] && id_head[i];
    end
  end

  // Reservation takes the lowest free slot
  assign alloc_onehot      = free_mask & (~free_mask + 1'b1);
  assign res_ready_o       = |free_mask;
  assign res_fire          = res_valid_i && res_ready_o;
  assign res_slot_onehot_o = res_fire ? alloc_onehot : '0;

  // Incoming response goes to the oldest waiting slot of its ID
  assign fill_onehot     = pick_oldest(wait_match, age_q);
  assign resp_in_ready_o = |wait_match;
  assign fill_fire       = resp_in_valid_i && resp_in_ready_o;

  // Output register empty or draining this cycle
  assign out_load   = !out_valid_q || resp_out_ready_i;
  assign rel_onehot = pick_oldest(eligible, age_q);

  always_comb begin
    rel_idx = '0;
    for (int i = 0; i < RespBanksCapacity; i++) begin
      if (rel_onehot[i]) begin
        rel_idx = SlotIdxWidth'(i);
      end
    end
  end

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < RespBanksCapacity; i++) begin
        state_q[i] <= SLOT_FREE;
      end
      age_cnt_q   <= '0;
      out_valid_q <= 1'b0;
    end else begin
      // Alloc, fill and release act on slots in different states
      for (int i = 0; i < RespBanksCapacity; i++) begin
        if (res_slot_onehot_o[i]) begin
          state_q[i] <= SLOT_WAIT_RESP;
        end else if (fill_fire && fill_onehot[i]) begin
          state_q[i] <= SLOT_FILLED;
        end else if (out_load && rel_onehot[i]) begin
          state_q[i] <= SLOT_FREE;
        end
      end
      if (res_fire) begin
        age_cnt_q <= age_cnt_q + 1'b1;
      end
      if (out_load) begin
        out_valid_q <= |eligible;
      end
    end
  end

  //////////////////////////////
  // Payload storage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < RespBanksCapacity; i++) begin
      if (res_slot_onehot_o[i]) begin
        id_q[i]  <= res_id_i;
        age_q[i] <= age_cnt_q;
      end
      if (fill_fire && fill_onehot[i]) begin
        resp_q[i] <= resp_i;
      end
    end
    if (out_load && |eligible) begin
      out_data_q <= resp_q[rel_idx];
    end
  end

  assign resp_out_valid_o = out_valid_q;
  assign resp_o           = out_data_q;

endmodule

//--- hdl/simmem_delay_bank.sv
/*
 * Delay bank
 * One down counter per response slot, flags the slots whose delay has run out
 */

`timescale 1ns/100ps

module simmem_delay_bank (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  // Slot being reserved this cycle, all zero when none
  input  logic [simmem_pkg::RespBanksCapacity-1:0] res_slot_onehot_i,
  // Delay to load into that slot
  input  logic [simmem_pkg::DelayWidth-1:0]        delay_i,

  // Multi-hot, one bit per slot whose counter sits at zero
  output logic [simmem_pkg::RespBanksCapacity-1:0] release_en_o
);

  import simmem_pkg::*;

  logic [DelayWidth-1:0]        cnt_q [RespBanksCapacity];
  logic [DelayWidth-1:0]        cnt_d [RespBanksCapacity];
  logic [RespBanksCapacity-1:0] cnt_zero;

  //////////////////////////////
  // Zero detection
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < RespBanksCapacity; i++) begin
      cnt_zero[i] = (cnt_q[i] == '0);
    end
  end

  // Free slots also read as zero, the response bank masks them
  assign release_en_o = cnt_zero;

  //////////////////////////////
  // Next counter values
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < RespBanksCapacity; i++) begin
      if (res_slot_onehot_i[i]) begin
        // New reservation restarts the count
        cnt_d[i] = delay_i;
      end else if (!cnt_zero[i]) begin
        cnt_d[i] = cnt_q[i] - DelayWidth'(1);
      end else begin
        // Expired, hold at zero
        cnt_d[i] = cnt_q[i];
      end
    end
  end

  //////////////////////////////
  // Counter registers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < RespBanksCapacity; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < RespBanksCapacity; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

endmodule

//--- hdl/simmem_delay_calc.sv
/*
 * Delay calculator
 * Single-bank DRAM row model, gives the delay of each write address
 */

`timescale 1ns/100ps

module simmem_delay_calc (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // Address of the current request, valid during a reservation
  input  logic [simmem_pkg::AddrWidth-1:0] addr_i,
  input  logic                             res_fire_i,

  // Delay for this address, combinational
  output logic [simmem_pkg::DelayWidth-1:0] delay_o
);

  import simmem_pkg::*;

  row_state_e          row_state_q;
  logic [RowWidth-1:0] open_row_q;
  logic [RowWidth-1:0] req_row;
  logic                row_match;

  // Row number of the incoming request
  assign req_row   = addr_i[AddrWidth-1:RowOffset];
  assign row_match = (open_row_q == req_row);

  //////////////////////////////
  // Delay lookup
  //////////////////////////////

  always_comb begin
    delay_o = DelayWidth'(RowMissDelay);
    unique case (row_state_q)
      ROW_CLOSED: begin
        // Activate only
        delay_o = DelayWidth'(RowMissDelay);
      end
      ROW_OPEN: begin
        if (row_match) begin
          delay_o = DelayWidth'(RowHitDelay);
        end else begin
          // Precharge, then activate
          delay_o = DelayWidth'(RowConflictDelay);
        end
      end
      default: begin
        delay_o = DelayWidth'(RowMissDelay);
      end
    endcase
  end

  //////////////////////////////
  // Row state
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      row_state_q <= ROW_CLOSED;
    end else if (res_fire_i) begin
      row_state_q <= ROW_OPEN;
    end
  end

  // Row number only meaningful once the row is open
  always_ff @(posedge clk_i) begin
    if (res_fire_i) begin
      open_row_q <= req_row;
    end
  end

endmodule

//--- hdl/simmem_pkg.sv
/*
 * Simulated memory controller, shared definitions
 * Widths, DRAM row delays, slot capacity, message structs and state enums
 */

package simmem_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Transaction ID and byte address
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;

  // Row number starts at this address bit
  localparam int unsigned RowOffset = 10;
  localparam int unsigned RowWidth  = AddrWidth - RowOffset;

  // Free-form user field, carried along with the response
  localparam int unsigned UserWidth = 8;

  //////////////////////////////
  // Response bank geometry
  //////////////////////////////

  localparam int unsigned RespBanksCapacity = 8;
  localparam int unsigned SlotIdxWidth      = 3;

  // Running reservation stamp, compared modulo its range
  localparam int unsigned AgeWidth = 16;

  //////////////////////////////
  // DRAM row model
  //////////////////////////////

  // Down counter width, must hold the largest delay
  localparam int unsigned DelayWidth = 5;

  // Delays in clock cycles
  localparam int unsigned RowHitDelay      = 4;
  localparam int unsigned RowMissDelay     = 12;
  localparam int unsigned RowConflictDelay = 16;

  //////////////////////////////
  // Messages
  //////////////////////////////

  // Write address request, passed through unchanged
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
    logic [2:0]           size;
    logic [1:0]           burst;
  } write_addr_req_t;

  // Write response
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [1:0]           resp;
    logic [UserWidth-1:0] user;
  } write_resp_t;

  //////////////////////////////
  // States
  //////////////////////////////

  typedef enum logic {
    ROW_CLOSED,
    ROW_OPEN
  } row_state_e;

  // Slot lifecycle: reserved on address, filled on response, freed on release
  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_WAIT_RESP,
    SLOT_FILLED
  } slot_state_e;

endpackage
